//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module fir_tb -o Vfir_tb

run: build
	@out=$$(./obj_dir/Vfir_tb); echo "$$out"; echo "$$out" | grep -qxF '** PASS **'

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module fir_tb

clean:
	rm -rf obj_dir

//--- common/fir_data_pkg.sv
//////////////////////////////////////////////////////////////////////
// Datapath number formats of the FIR block
// Coefficient width and type, Q15 scaling of the tap sum
//////////////////////////////////////////////////////////////////////

package fir_data_pkg;

    // Coefficients are Q15 fractions
    localparam int coef_width = 16;

    typedef logic signed [coef_width-1:0] coef_t;

    // Sum of Q15 products back to sample scale
    localparam int frac_shift = 15;

endpackage

//--- common/fir_regs_pkg.sv
//////////////////////////////////////////////////////////////////////
// APB register map of the FIR block
// Register offsets, control and coefficient word layouts, and the
// union that decodes one APB data word either way
//////////////////////////////////////////////////////////////////////

package fir_regs_pkg;

    localparam int apb_addr_width = 12;
    localparam int apb_data_width = 32;
    localparam int n_taps_width   = 8;

    // Register offsets
    localparam logic [apb_addr_width-1:0] addr_ctrl      = 12'h000;
    localparam logic [apb_addr_width-1:0] addr_coef_data = 12'h004;
    localparam logic [apb_addr_width-1:0] addr_coef_addr = 12'h008;

    // Control word, clear is a write-only strobe
    typedef struct packed {
        logic [apb_data_width-n_taps_width-3:0] reserved;
        logic                                   clear;
        logic                                   enable;
        logic [n_taps_width-1:0]                n_taps;
    } ctrl_fields_t;

    // Coefficient word, value in the low half
    typedef struct packed {
        logic [apb_data_width-fir_data_pkg::coef_width-1:0] reserved;
        fir_data_pkg::coef_t                                value;
    } coef_fields_t;

    // Same pwdata word, seen through whichever register is addressed
    typedef union packed {
        ctrl_fields_t ctrl;
        coef_fields_t coef;
    } apb_word_u;

endpackage

//--- flist.f
common/fir_data_pkg.sv
common/fir_regs_pkg.sv
hw/fir/fir_coef_mem.sv
hw/fir/fir_history.sv
hw/fir/fir_mac.sv
hw/fir/fir_ctrl.sv
hw/fir_top.sv
testbench/fir_assertions.sv
testbench/fir_tb.sv

//--- hw/fir/fir_coef_mem.sv
//////////////////////////////////////////////////////////////////////
// Coefficient memory
// One write port, registered read port
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_coef_mem #(
    parameter int MAX_TAPS = 32,
    localparam int tap_aw = $clog2(MAX_TAPS)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  logic [tap_aw-1:0]   waddr,
    input  fir_data_pkg::coef_t wdata,
    input  logic [tap_aw-1:0]   raddr,
    output fir_data_pkg::coef_t rdata
);

    fir_data_pkg::coef_t mem [MAX_TAPS];

    // Unloaded taps must read as zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MAX_TAPS; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hw/fir/fir_ctrl.sv
//////////////////////////////////////////////////////////////////////
// FIR controller
// APB register file, coefficient loading, tap sequencer FSM and the
// flag pipeline that times out_valid
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_ctrl #(
    parameter int MAX_TAPS = 32,
    localparam int tap_aw = $clog2(MAX_TAPS)
) (
    input  logic                                    clk,
    input  logic                                    rst,
    // APB slave
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [fir_regs_pkg::apb_addr_width-1:0] paddr,
    input  logic [fir_regs_pkg::apb_data_width-1:0] pwdata,
    output logic [fir_regs_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    // Stream handshakes
    input  logic                                    in_valid,
    output logic                                    in_ready,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    // Coefficient memory
    output logic                                    coef_we,
    output logic [tap_aw-1:0]                       coef_waddr,
    output fir_data_pkg::coef_t                     coef_wdata,
    output logic [tap_aw-1:0]                       coef_raddr,
    // Sample history
    output logic                                    hist_shift,
    output logic                                    hist_clear,
    output logic [tap_aw-1:0]                       hist_raddr,
    // MAC control, aligned with the read data
    output logic                                    mac_start,
    output logic                                    mac_step,
    output logic                                    mac_last
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_run  = 2'd1;
    localparam logic [1:0] st_hold = 2'd2;

    fir_regs_pkg::apb_word_u wr_word;
    fir_regs_pkg::apb_word_u rd_word;

    logic apb_access;
    logic apb_write;
    logic hit_ctrl;
    logic hit_coef_data;
    logic hit_coef_addr;

    logic [fir_regs_pkg::n_taps_width-1:0] n_taps_r;
    logic                                  enable_r;
    fir_data_pkg::coef_t                   coef_data_r;

    logic [1:0]                            state;
    logic [fir_regs_pkg::n_taps_width-1:0] tap_cnt;
    logic [fir_regs_pkg::n_taps_width-1:0] last_tap;
    logic                                  accept;
    logic                                  issue;
    logic                                  issue_last;

    // Tap flags after read, multiply and accumulate
    logic rd_step;
    logic rd_first;
    logic rd_last;
    logic mul_last;
    logic acc_last;
    logic out_valid_r;

    assign wr_word       = pwdata;
    assign apb_access    = psel & penable;
    assign apb_write     = apb_access & pwrite;
    assign hit_ctrl      = (paddr == fir_regs_pkg::addr_ctrl);
    assign hit_coef_data = (paddr == fir_regs_pkg::addr_coef_data);
    assign hit_coef_addr = (paddr == fir_regs_pkg::addr_coef_addr);

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = apb_access & ~(hit_ctrl | hit_coef_data | hit_coef_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            n_taps_r    <= '0;
            enable_r    <= 1'b0;
            coef_data_r <= '0;
        end else if (apb_write) begin
            if (hit_ctrl) begin
                n_taps_r <= wr_word.ctrl.n_taps;
                enable_r <= wr_word.ctrl.enable;
            end
            if (hit_coef_data) begin
                coef_data_r <= wr_word.coef.value;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (hit_ctrl) begin
            rd_word.ctrl.n_taps = n_taps_r;
            rd_word.ctrl.enable = enable_r;
        end else if (hit_coef_data || hit_coef_addr) begin
            rd_word.coef.value = coef_data_r;
        end
    end

    assign prdata = rd_word;

    // Address write commits the held coefficient, index wraps at MAX_TAPS
    assign coef_we    = apb_write & hit_coef_addr;
    assign coef_waddr = pwdata[tap_aw-1:0];
    assign coef_wdata = coef_data_r;
    assign hist_clear = apb_write & hit_ctrl & wr_word.ctrl.clear;

    assign in_ready   = (state == st_idle) & enable_r & (n_taps_r != '0);
    assign accept     = in_valid & in_ready;
    assign issue      = (state == st_run);
    assign issue_last = issue & (tap_cnt == last_tap);

    assign hist_shift = accept;
    assign coef_raddr = tap_cnt[tap_aw-1:0];
    assign hist_raddr = tap_cnt[tap_aw-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            tap_cnt  <= '0;
            last_tap <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state    <= st_run;
                        tap_cnt  <= '0;
                        // Tap count sampled per sample
                        last_tap <= n_taps_r - 1'b1;
                    end
                end
                st_run: begin
                    tap_cnt <= tap_cnt + 1'b1;
                    if (issue_last) begin
                        state <= st_hold;
                    end
                end
                st_hold: begin
                    // Wait for drain and the output transfer
                    if (out_valid_r && out_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_step     <= 1'b0;
            rd_first    <= 1'b0;
            rd_last     <= 1'b0;
            mul_last    <= 1'b0;
            acc_last    <= 1'b0;
            out_valid_r <= 1'b0;
        end else begin
            rd_step  <= issue;
            rd_first <= issue & (tap_cnt == '0);
            rd_last  <= issue_last;
            mul_last <= rd_last;
            acc_last <= mul_last;
            if (acc_last) begin
                out_valid_r <= 1'b1;
            end else if (out_ready) begin
                out_valid_r <= 1'b0;
            end
        end
    end

    assign mac_step  = rd_step;
    assign mac_start = rd_first;
    assign mac_last  = rd_last;
    assign out_valid = out_valid_r;

endmodule

//--- hw/fir/fir_history.sv
//////////////////////////////////////////////////////////////////////
// Sample history
// Shift register of accepted samples, newest at index 0,
// with clear and a registered indexed read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_history #(
    parameter int MAX_TAPS     = 32,
    parameter int SAMPLE_WIDTH = 16,
    localparam int tap_aw = $clog2(MAX_TAPS)
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           shift,
    input  logic                           clear,
    input  logic signed [SAMPLE_WIDTH-1:0] din,
    input  logic [tap_aw-1:0]              raddr,
    output logic signed [SAMPLE_WIDTH-1:0] rdata
);

    logic signed [SAMPLE_WIDTH-1:0] hist [MAX_TAPS];

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < MAX_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else if (shift) begin
            // Oldest sample falls off the top
            for (int i = MAX_TAPS - 1; i > 0; i--) begin
                hist[i] <= hist[i-1];
            end
            hist[0] <= din;
        end
    end

    // Same latency as the coefficient read
    always_ff @(posedge clk) begin
        rdata <= hist[raddr];
    end

endmodule

//--- hw/fir/fir_mac.sv
//////////////////////////////////////////////////////////////////////
// Multiply-accumulate pipeline
// Registered product, accumulator, Q15 shift and saturation
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_mac #(
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           step,
    input  logic                           last,
    input  fir_data_pkg::coef_t            coef,
    input  logic signed [SAMPLE_WIDTH-1:0] sample,
    output logic signed [SAMPLE_WIDTH-1:0] result
);

    // Headroom for 64 full-scale products
    localparam int max_terms  = 64;
    localparam int prod_width = SAMPLE_WIDTH + fir_data_pkg::coef_width;
    localparam int acc_width  = prod_width + $clog2(max_terms);

    localparam logic signed [acc_width-1:0] sat_max =
        {{(acc_width - SAMPLE_WIDTH + 1){1'b0}}, {(SAMPLE_WIDTH - 1){1'b1}}};
    localparam logic signed [acc_width-1:0] sat_min = ~sat_max;

    logic signed [prod_width-1:0] prod;
    logic signed [acc_width-1:0]  prod_ext;
    logic signed [acc_width-1:0]  acc;
    logic signed [acc_width-1:0]  acc_shifted;
    logic                         start_d;
    logic                         step_d;
    logic                         last_d;
    logic                         acc_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_d  <= 1'b0;
            step_d   <= 1'b0;
            last_d   <= 1'b0;
            acc_done <= 1'b0;
        end else begin
            start_d  <= start;
            step_d   <= step;
            last_d   <= last;
            acc_done <= last_d & step_d;
        end
    end

    // Stage 1 multiply
    always_ff @(posedge clk) begin
        prod <= sample * coef;
    end

    assign prod_ext = {{(acc_width - prod_width){prod[prod_width-1]}}, prod};

    // Stage 2, first tap loads instead of adding
    always_ff @(posedge clk) begin
        if (step_d) begin
            acc <= start_d ? prod_ext : acc + prod_ext;
        end
    end

    assign acc_shifted = acc >>> fir_data_pkg::frac_shift;

    // Result held until the next sample completes
    always_ff @(posedge clk) begin
        if (acc_done) begin
            if (acc_shifted > sat_max) begin
                result <= sat_max[SAMPLE_WIDTH-1:0];
            end else if (acc_shifted < sat_min) begin
                result <= sat_min[SAMPLE_WIDTH-1:0];
            end else begin
                result <= acc_shifted[SAMPLE_WIDTH-1:0];
            end
        end
    end

endmodule

//--- hw/fir_top.sv
//////////////////////////////////////////////////////////////////////
// FIR filter top level
// Controller, coefficient memory, sample history and MAC
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_top #(
    parameter int MAX_TAPS     = 32,
    parameter int SAMPLE_WIDTH = 16
) (
    input  logic                                    clk,
    input  logic                                    rst,
    // APB configuration port
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [fir_regs_pkg::apb_addr_width-1:0] paddr,
    input  logic [fir_regs_pkg::apb_data_width-1:0] pwdata,
    output logic [fir_regs_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,
    // Sample streams
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic signed [SAMPLE_WIDTH-1:0]          in_data,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic signed [SAMPLE_WIDTH-1:0]          out_data
);

    localparam int tap_aw = $clog2(MAX_TAPS);

    logic                           coef_we;
    logic [tap_aw-1:0]              coef_waddr;
    fir_data_pkg::coef_t            coef_wdata;
    logic [tap_aw-1:0]              coef_raddr;
    fir_data_pkg::coef_t            coef_rdata;
    logic                           hist_shift;
    logic                           hist_clear;
    logic [tap_aw-1:0]              hist_raddr;
    logic signed [SAMPLE_WIDTH-1:0] hist_rdata;
    logic                           mac_start;
    logic                           mac_step;
    logic                           mac_last;

    fir_ctrl #(
        .MAX_TAPS(MAX_TAPS)
    ) u_ctrl (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .coef_we(coef_we),
        .coef_waddr(coef_waddr),
        .coef_wdata(coef_wdata),
        .coef_raddr(coef_raddr),
        .hist_shift(hist_shift),
        .hist_clear(hist_clear),
        .hist_raddr(hist_raddr),
        .mac_start(mac_start),
        .mac_step(mac_step),
        .mac_last(mac_last)
    );

    fir_coef_mem #(
        .MAX_TAPS(MAX_TAPS)
    ) u_coef_mem (
        .clk(clk),
        .rst(rst),
        .we(coef_we),
        .waddr(coef_waddr),
        .wdata(coef_wdata),
        .raddr(coef_raddr),
        .rdata(coef_rdata)
    );

    fir_history #(
        .MAX_TAPS(MAX_TAPS),
        .SAMPLE_WIDTH(SAMPLE_WIDTH)
    ) u_history (
        .clk(clk),
        .rst(rst),
        .shift(hist_shift),
        .clear(hist_clear),
        .din(in_data),
        .raddr(hist_raddr),
        .rdata(hist_rdata)
    );

    fir_mac #(
        .SAMPLE_WIDTH(SAMPLE_WIDTH)
    ) u_mac (
        .clk(clk),
        .rst(rst),
        .start(mac_start),
        .step(mac_step),
        .last(mac_last),
        .coef(coef_rdata),
        .sample(hist_rdata),
        .result(out_data)
    );

endmodule

//--- testbench/fir_assertions.sv
//////////////////////////////////////////////////////////////////////
// Protocol assertions bound to the FIR controller
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_assertions (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic in_ready,
    input logic out_valid,
    input logic out_ready
);

    // No wait states
    a_pready: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped");

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped under back-pressure");

    a_one_side: assert property (@(posedge clk) disable iff (rst)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high together");

    a_slverr: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable)
        else $error("pslverr outside an access cycle");

endmodule

bind fir_ctrl fir_assertions u_assertions (
    .clk(clk),
    .rst(rst),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .pslverr(pslverr),
    .in_ready(in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

//--- testbench/fir_stim.txt
# W addr data | R addr exp_data exp_err | S sample | O expected output | G stall cycles
# All values hex
W 004 FFFF8000
R 004 00008000 0
R 00C 00000000 1
W 004 00001000
W 008 00000000
W 004 00002000
W 008 00000001
W 004 00000800
W 008 00000002
W 004 0000F000
W 008 00000003
W 004 00000400
W 008 00000004
W 004 00007FFF
W 008 00000005
W 004 0000C000
W 008 00000006
W 004 00000100
W 008 00000007
W 000 00000108
R 000 00000108 0
R 008 00000100 0
S 7FFF
O 0FFF
S 0000
O 1FFF
G 0C
S 0000
O 07FF
S 0000
O F000
S 0000
O 03FF
S 0000
O 7FFE
S 0000
O C000
S 0000
O 00FF
S 4000
O 0800
W 004 00007FFF
W 008 00000000
W 008 00000001
W 008 00000002
W 000 00000303
R 000 00000103 0
S 7FFF
O 7FFE
S 7FFF
O 7FFF
S 7FFF
O 7FFF
W 004 FFFF8000
W 008 00000000
W 008 00000001
W 008 00000002
W 000 00000303
S 7FFF
O 8001
G 14
S 7FFF
O 8000
S 7FFF
O 8000
R 008 00008000 0

//--- testbench/fir_tb.sv
//////////////////////////////////////////////////////////////////////
// FIR filter testbench
// Clock, reset, APB and stream drivers, stim file reader,
// output monitor with latency measurement and compare tasks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module fir_tb;

    localparam int max_taps = 16;
    localparam int sw       = 16;
    localparam int aw       = fir_regs_pkg::apb_addr_width;
    localparam int dw       = fir_regs_pkg::apb_data_width;

    logic                 clk;
    logic                 rst;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [aw-1:0]        paddr;
    logic [dw-1:0]        pwdata;
    logic [dw-1:0]        prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 in_valid;
    logic                 in_ready;
    logic signed [sw-1:0] in_data;
    logic                 out_valid;
    logic                 out_ready;
    logic signed [sw-1:0] out_data;

    // Parsed stim file
    byte                  op_cmd [$];
    logic [31:0]          op_a [$];
    logic [31:0]          op_b [$];
    logic [31:0]          op_c [$];
    logic signed [sw-1:0] exp_q [$];

    int   cycle = 0;
    int   cycle_limit = 0;
    int   gap_left = 0;
    int   mismatch_errors = 0;
    int   other_errors = 0;
    int   acc_cycle = 0;
    int   lat_exp = 0;
    int   cur_taps = 0;
    logic out_valid_prev = 1'b0;

    fir_top #(
        .MAX_TAPS(max_taps),
        .SAMPLE_WIDTH(sw)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data)
    );

    always #2 clk = ~clk;

    task automatic check_reg(input logic [dw-1:0] got, input logic got_err,
                             input logic [dw-1:0] exp, input logic exp_err);
        if (got !== exp || got_err !== exp_err) begin
            $display("MISMATCH @%0t: register read got %h err %b, expected %h err %b",
                     $time, got, got_err, exp, exp_err);
            mismatch_errors++;
        end
    endtask

    task automatic check_sample(input logic signed [sw-1:0] got,
                                input logic signed [sw-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH @%0t: output sample got %h, expected %h", $time, got, exp);
            mismatch_errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH @%0t: output latency %0d cycles, expected %0d",
                     $time, got, exp);
            mismatch_errors++;
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [aw-1:0] addr,
                                input logic [dw-1:0] data,
                                output logic [dw-1:0] rdata, output logic err);
        @(posedge clk);
        #0.5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        // Zero wait states, every access completes in one cycle
        if (pready !== 1'b1) begin
            $display("APB access to %h at %0t was not completed, pready is low",
                     addr, $time);
            other_errors++;
        end
        @(posedge clk);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_sample(input logic signed [sw-1:0] value);
        @(posedge clk);
        #0.5;
        in_valid = 1'b1;
        in_data  = value;
        do begin
            @(negedge clk);
        end while (!in_ready);
        @(posedge clk);
        #0.5;
        in_valid = 1'b0;
    endtask

    // Register traffic only while the filter is idle
    task automatic wait_drain();
        while (exp_q.size() != 0 || out_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic load_stim(output int n_samples, output int n_gap);
        int          fd;
        int          code;
        byte         c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        reg [8*256-1:0] line;
        n_samples = 0;
        n_gap     = 0;
        fd = $fopen("testbench/fir_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stim file testbench/fir_stim.txt");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            a = '0;
            b = '0;
            e = '0;
            code = $fscanf(fd, " %c", c);
            if (code != 1) begin
                break;
            end
            if (c == "#") begin
                code = $fgets(line, fd);
                continue;
            end
            if (c == "R") begin
                code = $fscanf(fd, " %h %h %h", a, b, e);
            end else if (c == "W") begin
                code = $fscanf(fd, " %h %h", a, b);
            end else begin
                code = $fscanf(fd, " %h", a);
            end
            if (c == "S") begin
                n_samples++;
            end
            if (c == "G") begin
                n_gap += int'(a);
            end
            op_cmd.push_back(c);
            op_a.push_back(a);
            op_b.push_back(b);
            op_c.push_back(e);
        end
        $fclose(fd);
    endtask

    // Stall pattern, fixed gaps first, random drops otherwise
    always @(posedge clk) begin
        #0.5;
        if (gap_left > 0) begin
            out_ready = 1'b0;
            gap_left--;
        end else begin
            out_ready = ($urandom % 4) != 0;
        end
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle_limit > 0 && cycle > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    // Mid-cycle monitor of both streams
    always @(negedge clk) begin
        if (!rst) begin
            if (in_valid && in_ready) begin
                acc_cycle = cycle;
                lat_exp   = cur_taps + 3;
            end
            if (out_valid && !out_valid_prev) begin
                check_latency(cycle - acc_cycle - 1, lat_exp);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output sample %h arrived with no expected value", out_data);
                    other_errors++;
                end else begin
                    check_sample(out_data, exp_q.pop_front());
                end
            end
            out_valid_prev = out_valid;
        end
    end

    initial begin
        int          n_samples;
        int          n_gap;
        logic [31:0] rdata;
        logic        err;
        clk       = 1'b0;
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        void'($urandom(94828));
        load_stim(n_samples, n_gap);
        cycle_limit = n_samples * (max_taps + 4) + n_gap + 200;
        repeat (5) @(posedge clk);
        #0.5;
        rst = 1'b0;
        for (int i = 0; i < op_cmd.size(); i++) begin
            case (op_cmd[i])
                "W": begin
                    wait_drain();
                    apb_transfer(1'b1, op_a[i][aw-1:0], op_b[i], rdata, err);
                    if (op_a[i][aw-1:0] == fir_regs_pkg::addr_ctrl) begin
                        cur_taps = int'(op_b[i][7:0]);
                    end
                end
                "R": begin
                    wait_drain();
                    apb_transfer(1'b0, op_a[i][aw-1:0], '0, rdata, err);
                    check_reg(rdata, err, op_b[i], op_c[i][0]);
                end
                "S": send_sample(op_a[i][sw-1:0]);
                "O": exp_q.push_back(op_a[i][sw-1:0]);
                "G": begin
                    @(negedge clk);
                    gap_left = int'(op_a[i]);
                end
                default: begin
                    $display("Unknown stim command %c", op_cmd[i]);
                    other_errors++;
                end
            endcase
        end
        wait_drain();
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
